//--- build.f
data_sram.sv
lsu_pkg.sv
mem_bus_pkg.sv
uncache_channel.sv
lsu.sv
lsu_top.sv
tb_lsu.sv

//--- data_sram.sv
`timescale 1ns/10ps

module data_sram #(
    parameter int SRAM_WORDS = 256
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        sram_valid,
    input  logic [31:0] sram_addr,
    input  logic [31:0] sram_wdata,
    input  logic [3:0]  sram_wstrb,
    output logic [31:0] sram_rdata,
    output logic        sram_ready
);

    localparam int IDX_W = $clog2(SRAM_WORDS);

    logic [31:0]      mem [0:SRAM_WORDS-1];
    logic [IDX_W-1:0] word_idx;

    // Byte offset dropped, upper bits alias
    assign word_idx = sram_addr[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (sram_valid) begin
            for (int i = 0; i < 4; i++) begin
                if (sram_wstrb[i]) begin
                    mem[word_idx][8*i +: 8] <= sram_wdata[8*i +: 8];
                end
            end
        end
    end

    // Registered read, zero strobe only
    always_ff @(posedge clk) begin
        if (sram_valid && sram_wstrb == 4'b0000) begin
            sram_rdata <= mem[word_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sram_ready <= 1'b0;
        end else begin
            sram_ready <= sram_valid;
        end
    end

endmodule

//--- lsu.sv
`timescale 1ns/10ps

module lsu (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       cpu_valid,
    input  lsu_pkg::cpu_req_t          cpu_req,
    output logic                       cpu_ready,
    output logic [lsu_pkg::DATA_W-1:0] cpu_rdata,
    output logic                       cpu_data_valid,
    input  logic                       cpu_store_commit,
    input  logic                       cpu_flush,

    output logic                       sram_valid,
    output logic [lsu_pkg::ADDR_W-1:0] sram_addr,
    output logic [lsu_pkg::DATA_W-1:0] sram_wdata,
    output logic [lsu_pkg::STRB_W-1:0] sram_wstrb,
    input  logic [lsu_pkg::DATA_W-1:0] sram_rdata,
    input  logic                       sram_ready,

    output logic                       unc_valid,
    output logic [lsu_pkg::ADDR_W-1:0] unc_addr,
    input  logic                       unc_ready,
    input  logic                       unc_data_ok,
    input  logic [lsu_pkg::DATA_W-1:0] unc_rdata
);

    lsu_pkg::lsu_state_e        state;
    lsu_pkg::lsu_state_e        next_state;
    lsu_pkg::cpu_req_t          req_q;
    logic                       accept;
    logic                       is_store;
    logic [lsu_pkg::DATA_W-1:0] load_word;
    logic [7:0]                 load_byte;
    logic [15:0]                load_half;

    assign is_store  = cpu_req.wstrb != '0;
    // A flush from write-back blocks acceptance
    assign cpu_ready = (state == lsu_pkg::IDLE) && !cpu_flush;
    assign accept    = cpu_valid && cpu_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lsu_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            lsu_pkg::IDLE: begin
                if (accept && is_store) begin
                    next_state = lsu_pkg::STORE_COMMIT_WAIT;
                end else if (accept && cpu_req.uncached) begin
                    next_state = lsu_pkg::UNCACHE_REQ_SEND;
                end
            end
            lsu_pkg::STORE_COMMIT_WAIT: begin
                // Flush wins over a commit in the same cycle
                if (cpu_flush) begin
                    next_state = lsu_pkg::IDLE;
                end else if (cpu_store_commit) begin
                    next_state = lsu_pkg::STORE_REQ_SEND;
                end
            end
            lsu_pkg::STORE_REQ_SEND: begin
                if (sram_ready) begin
                    next_state = lsu_pkg::IDLE;
                end
            end
            lsu_pkg::UNCACHE_REQ_SEND: begin
                if (unc_ready) begin
                    next_state = lsu_pkg::UNCACHE_REQ_WAIT;
                end
            end
            lsu_pkg::UNCACHE_REQ_WAIT: begin
                if (unc_data_ok) begin
                    next_state = lsu_pkg::IDLE;
                end
            end
            default: next_state = lsu_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= cpu_req;
        end
    end

    // Cached loads go out straight from the CPU port
    always_comb begin
        sram_valid = 1'b0;
        sram_addr  = cpu_req.addr;
        sram_wdata = '0;
        sram_wstrb = '0;
        if (state == lsu_pkg::STORE_REQ_SEND) begin
            // One write, then wait for the ack
            sram_valid = !sram_ready;
            sram_addr  = req_q.addr;
            sram_wdata = req_q.wdata;
            sram_wstrb = req_q.wstrb;
        end else if (state == lsu_pkg::IDLE) begin
            sram_valid = accept && !is_store && !cpu_req.uncached;
        end
    end

    assign unc_valid = state == lsu_pkg::UNCACHE_REQ_SEND;
    assign unc_addr  = req_q.addr;

    assign load_word = req_q.uncached ? unc_rdata : sram_rdata;

    always_comb begin
        load_byte = load_word[{req_q.addr[1:0], 3'b000} +: 8];
        load_half = req_q.addr[1] ? load_word[31:16] : load_word[15:0];
        case (req_q.load_type)
            lsu_pkg::LB:  cpu_rdata = {{24{load_byte[7]}}, load_byte};
            lsu_pkg::LBU: cpu_rdata = {24'd0, load_byte};
            lsu_pkg::LH:  cpu_rdata = {{16{load_half[15]}}, load_half};
            lsu_pkg::LHU: cpu_rdata = {16'd0, load_half};
            default:      cpu_rdata = load_word;
        endcase
    end

    // In IDLE the SRAM ack can only belong to a load
    always_comb begin
        case (state)
            lsu_pkg::IDLE:             cpu_data_valid = sram_ready;
            lsu_pkg::UNCACHE_REQ_WAIT: cpu_data_valid = unc_data_ok;
            default:                   cpu_data_valid = 1'b0;
        endcase
    end

endmodule

//--- lsu_cases.txt
# op addr data field flush expected; op 0 store, 1 cached load, 2 uncached load
# field is the store strobe or the load type (0 LB, 1 LH, 2 LW, 4 LBU, 5 LHU)
0 00000010 12345678 f 0 00000000
1 00000010 00000000 2 0 12345678
0 00000020 8899aabb f 0 00000000
0 00000020 000000cc 1 0 00000000
0 00000020 00f10000 4 0 00000000
0 00000020 7e000000 8 0 00000000
1 00000020 00000000 2 0 7ef1aacc
1 00000020 00000000 0 0 ffffffcc
1 00000020 00000000 4 0 000000cc
1 00000021 00000000 0 0 ffffffaa
1 00000021 00000000 4 0 000000aa
1 00000022 00000000 0 0 fffffff1
1 00000022 00000000 4 0 000000f1
1 00000023 00000000 0 0 0000007e
1 00000023 00000000 4 0 0000007e
1 00000020 00000000 1 0 ffffaacc
1 00000020 00000000 5 0 0000aacc
1 00000022 00000000 1 0 00007ef1
1 00000022 00000000 5 0 00007ef1
0 00000030 11112222 f 0 00000000
0 00000032 c3d40000 c 0 00000000
1 00000032 00000000 1 0 ffffc3d4
1 00000030 00000000 5 0 00002222
1 00000030 00000000 2 0 c3d42222
0 00000010 deadbeef f 1 00000000
1 00000010 00000000 2 0 12345678
0 00000011 00005500 2 1 00000000
1 00000011 00000000 4 0 00000056
2 00001000 00000000 2 0 a5a54a5a
2 00001004 00000000 2 0 a5a54a5e
2 80000008 00000000 2 0 25a55a52
2 0000100c 00000000 2 0 a5a54a56
2 00002010 00000000 2 0 a5a57a4a
2 00001002 00000000 1 0 ffffa5a5
2 00001001 00000000 4 0 0000004a
2 12345670 00000000 2 0 b7910c2a
1 00000032 00000000 5 0 0000c3d4

//--- lsu_pkg.sv
package lsu_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // Load width and sign, bit 2 set means zero extension
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_type_e;

    // Nonzero strobe marks a store
    typedef struct packed {
        logic              uncached;
        load_type_e        load_type;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
    } cpu_req_t;

    typedef enum logic [2:0] {
        IDLE,
        STORE_COMMIT_WAIT,
        STORE_REQ_SEND,
        UNCACHE_REQ_SEND,
        UNCACHE_REQ_WAIT
    } lsu_state_e;

endpackage

//--- lsu_top.sv
`timescale 1ns/10ps

module lsu_top #(
    parameter int SRAM_WORDS  = 256,
    parameter int BUS_CREDITS = 2
) (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       cpu_valid,
    input  lsu_pkg::cpu_req_t          cpu_req,
    output logic                       cpu_ready,
    output logic [lsu_pkg::DATA_W-1:0] cpu_rdata,
    output logic                       cpu_data_valid,
    input  logic                       cpu_store_commit,
    input  logic                       cpu_flush,

    output logic                       bus_req_valid,
    output mem_bus_pkg::bus_req_t      bus_req,
    input  logic                       bus_credit,
    input  logic                       bus_resp_valid,
    input  mem_bus_pkg::bus_resp_t     bus_resp
);

    logic                       sram_valid;
    logic [lsu_pkg::ADDR_W-1:0] sram_addr;
    logic [lsu_pkg::DATA_W-1:0] sram_wdata;
    logic [lsu_pkg::STRB_W-1:0] sram_wstrb;
    logic [lsu_pkg::DATA_W-1:0] sram_rdata;
    logic                       sram_ready;

    logic                       unc_valid;
    logic [lsu_pkg::ADDR_W-1:0] unc_addr;
    logic                       unc_ready;
    logic                       unc_data_ok;
    logic [lsu_pkg::DATA_W-1:0] unc_rdata;

    lsu lsu_inst (
        .clk(clk), .rst(rst),
        .cpu_valid(cpu_valid), .cpu_req(cpu_req), .cpu_ready(cpu_ready),
        .cpu_rdata(cpu_rdata), .cpu_data_valid(cpu_data_valid),
        .cpu_store_commit(cpu_store_commit), .cpu_flush(cpu_flush),
        .sram_valid(sram_valid), .sram_addr(sram_addr), .sram_wdata(sram_wdata),
        .sram_wstrb(sram_wstrb), .sram_rdata(sram_rdata), .sram_ready(sram_ready),
        .unc_valid(unc_valid), .unc_addr(unc_addr), .unc_ready(unc_ready),
        .unc_data_ok(unc_data_ok), .unc_rdata(unc_rdata)
    );

    data_sram #(.SRAM_WORDS(SRAM_WORDS)) data_sram_inst (
        .clk(clk), .rst(rst),
        .sram_valid(sram_valid), .sram_addr(sram_addr), .sram_wdata(sram_wdata),
        .sram_wstrb(sram_wstrb), .sram_rdata(sram_rdata), .sram_ready(sram_ready)
    );

    uncache_channel #(.BUS_CREDITS(BUS_CREDITS)) uncache_channel_inst (
        .clk(clk), .rst(rst),
        .unc_valid(unc_valid), .unc_addr(unc_addr), .unc_ready(unc_ready),
        .unc_data_ok(unc_data_ok), .unc_rdata(unc_rdata),
        .bus_req_valid(bus_req_valid), .bus_req(bus_req), .bus_credit(bus_credit),
        .bus_resp_valid(bus_resp_valid), .bus_resp(bus_resp)
    );

endmodule

//--- mem_bus_pkg.sv
package mem_bus_pkg;

    localparam int BUS_ADDR_W = 32;
    localparam int BUS_DATA_W = 32;
    localparam int TAG_W      = 8;

    // Only reads are issued today
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

    typedef struct packed {
        bus_op_e               op;
        logic [BUS_ADDR_W-1:0] addr;
        logic [TAG_W-1:0]      tag;
    } bus_req_t;

    // Tag echoed by the device
    typedef struct packed {
        logic [TAG_W-1:0]      tag;
        logic [BUS_DATA_W-1:0] data;
    } bus_resp_t;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Build the LSU testbench with Verilator and run it from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary -j 0 --top-module tb_lsu -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/Vtb_lsu 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- tb_lsu.sv
`timescale 1ns/10ps

module tb_lsu;

    localparam int          CLK_PERIOD  = 20;
    localparam int          SAMPLE_DLY  = CLK_PERIOD / 4;
    localparam int          SRAM_WORDS  = 256;
    localparam int          BUS_CREDITS = 2;
    localparam int          SEED        = 11;
    localparam logic [31:0] DEVICE_KEY  = 32'hA5A5_5A5A;

    // One line of the cases file
    typedef struct packed {
        logic [1:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  field;
        logic        flush;
        logic [31:0] expected;
    } case_t;

    logic                   clk;
    logic                   rst;
    logic                   cpu_valid;
    lsu_pkg::cpu_req_t      cpu_req;
    logic                   cpu_ready;
    logic [31:0]            cpu_rdata;
    logic                   cpu_data_valid;
    logic                   cpu_store_commit;
    logic                   cpu_flush;
    logic                   bus_req_valid;
    mem_bus_pkg::bus_req_t  bus_req;
    logic                   bus_credit;
    logic                   bus_resp_valid;
    mem_bus_pkg::bus_resp_t bus_resp;

    case_t       cases [$];
    int          resp_delays [$];
    int          credit_delays [$];
    logic [31:0] shadow_mem [logic [31:0]];
    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    lsu_top #(.SRAM_WORDS(SRAM_WORDS), .BUS_CREDITS(BUS_CREDITS)) lsu_top_inst (.*);

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin : watchdog
        wait (cycle_limit != 0);
        wait (cycle_count >= cycle_limit);
        $display("timeout: run stopped after %0d cycles with %0d errors", cycle_count, errors);
        $display("*** TEST FAILED ***");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // A set sign bit subtracts 2^8 or 2^16 from the selected lane
    function automatic logic [31:0] extend_load(input logic [31:0] word,
                                                input logic [1:0] offset,
                                                input logic [2:0] ltype);
        logic [31:0] shifted;
        logic [31:0] low_byte;
        logic [31:0] low_half;
        shifted  = word >> (8 * offset);
        low_byte = shifted & 32'h0000_00ff;
        low_half = shifted & 32'h0000_ffff;
        case (ltype)
            lsu_pkg::LB:  return shifted[7] ? low_byte - 32'h0000_0100 : low_byte;
            lsu_pkg::LBU: return low_byte;
            lsu_pkg::LH:  return shifted[15] ? low_half - 32'h0001_0000 : low_half;
            lsu_pkg::LHU: return low_half;
            default:      return word;
        endcase
    endfunction

    task automatic load_cases();
        int          fd;
        int          fields;
        int          op_val;
        int          flush_val;
        logic [31:0] addr_val;
        logic [31:0] data_val;
        logic [31:0] field_val;
        logic [31:0] exp_val;
        string       line;
        case_t       c;
        fd = $fopen("lsu_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open lsu_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                fields = $sscanf(line, "%d %h %h %h %d %h", op_val, addr_val, data_val,
                                 field_val, flush_val, exp_val);
                if (fields == 6) begin
                    c.op       = op_val[1:0];
                    c.addr     = addr_val;
                    c.data     = data_val;
                    c.field    = field_val[3:0];
                    c.flush    = flush_val[0];
                    c.expected = exp_val;
                    cases.push_back(c);
                end
            end
            $fclose(fd);
        end
    endtask

    // Called on a falling edge, returns a quarter period later with cpu_ready high
    task automatic wait_ready();
        #(SAMPLE_DLY);
        while (!cpu_ready) begin
            @(negedge clk);
            #(SAMPLE_DLY);
        end
    endtask

    task automatic send_request(input case_t c);
        @(negedge clk);
        cpu_valid         = 1'b1;
        cpu_req.uncached  = c.op == 2'd2;
        cpu_req.load_type = (c.op == 2'd0) ? lsu_pkg::LW : lsu_pkg::load_type_e'(c.field[2:0]);
        cpu_req.addr      = c.addr;
        cpu_req.wdata     = c.data;
        cpu_req.wstrb     = (c.op == 2'd0) ? c.field : 4'h0;
        wait_ready();
        // Accepted on the rising edge just passed
        @(negedge clk);
        cpu_valid = 1'b0;
    endtask

    task automatic run_store(input case_t c);
        logic [31:0] word_addr;
        logic [31:0] word;
        int          delay;
        word_addr = {c.addr[31:2], 2'b00};
        delay     = int'($urandom % 4);
        send_request(c);
        repeat (delay) begin
            @(negedge clk);
        end
        if (c.flush) begin
            cpu_flush = 1'b1;
        end else begin
            cpu_store_commit = 1'b1;
        end
        @(negedge clk);
        cpu_flush        = 1'b0;
        cpu_store_commit = 1'b0;
        wait_ready();
        if (!c.flush) begin
            word = shadow_mem.exists(word_addr) ? shadow_mem[word_addr] : 32'h0;
            for (int i = 0; i < 4; i++) begin
                if (c.field[i]) begin
                    word[8*i +: 8] = c.data[8*i +: 8];
                end
            end
            shadow_mem[word_addr] = word;
        end
    endtask

    task automatic run_cached_load(input case_t c);
        logic [31:0] model;
        model = extend_load(shadow_mem[{c.addr[31:2], 2'b00}], c.addr[1:0], c.field[2:0]);
        send_request(c);
        #(SAMPLE_DLY);
        // Data due in the cycle right after acceptance
        check_value("cpu_data_valid", {31'd0, cpu_data_valid}, 32'd1);
        check_value("cpu_rdata", cpu_rdata, c.expected);
        check_value("cpu_rdata against shadow memory", cpu_rdata, model);
    endtask

    task automatic run_uncached_load(input case_t c);
        logic [31:0] model;
        model = extend_load({c.addr[31:2], 2'b00} ^ DEVICE_KEY, c.addr[1:0], c.field[2:0]);
        send_request(c);
        #(SAMPLE_DLY);
        while (!cpu_data_valid) begin
            check_value("cpu_ready", {31'd0, cpu_ready}, 32'd0);
            @(negedge clk);
            #(SAMPLE_DLY);
        end
        check_value("cpu_ready", {31'd0, cpu_ready}, 32'd0);
        check_value("cpu_rdata", cpu_rdata, c.expected);
        check_value("cpu_rdata against device model", cpu_rdata, model);
    endtask

    // Device model answers each request in order and returns one credit per request
    initial begin : device
        int          resp_wait [$];
        int          credit_wait [$];
        logic [31:0] resp_addr [$];
        logic [7:0]  resp_tag [$];
        int          sent;
        int          in_flight;
        bus_credit     = 1'b0;
        bus_resp_valid = 1'b0;
        bus_resp       = '0;
        sent           = 0;
        in_flight      = 0;
        forever begin
            @(negedge clk);
            bus_credit     = 1'b0;
            bus_resp_valid = 1'b0;
            if (resp_wait.size() > 0) begin
                if (resp_wait[0] == 0) begin
                    bus_resp_valid = 1'b1;
                    bus_resp.tag   = resp_tag.pop_front();
                    bus_resp.data  = resp_addr.pop_front() ^ DEVICE_KEY;
                    void'(resp_wait.pop_front());
                end else begin
                    resp_wait[0] = resp_wait[0] - 1;
                end
            end
            if (credit_wait.size() > 0) begin
                if (credit_wait[0] == 0) begin
                    bus_credit = 1'b1;
                    void'(credit_wait.pop_front());
                end else begin
                    credit_wait[0] = credit_wait[0] - 1;
                end
            end
            #(SAMPLE_DLY);
            if (!rst) begin
                if (bus_req_valid && in_flight >= BUS_CREDITS) begin
                    errors++;
                    $display("request sent at %0t ns with all credits in use", $time);
                end
                if (bus_credit) begin
                    in_flight--;
                end
                if (bus_req_valid) begin
                    in_flight++;
                    check_value("bus_req.op", {31'd0, bus_req.op},
                                {31'd0, mem_bus_pkg::OP_READ});
                    check_value("bus_req.tag", {24'd0, bus_req.tag}, {24'd0, sent[7:0]});
                    resp_addr.push_back(bus_req.addr);
                    resp_tag.push_back(bus_req.tag);
                    resp_wait.push_back(sent < resp_delays.size() ? resp_delays[sent] : 0);
                    credit_wait.push_back(sent < credit_delays.size() ? credit_delays[sent] : 0);
                    sent++;
                end
            end
        end
    end

    initial begin : main
        rst              = 1'b1;
        cpu_valid        = 1'b0;
        cpu_req          = '0;
        cpu_store_commit = 1'b0;
        cpu_flush        = 1'b0;
        void'($urandom(SEED));
        load_cases();
        foreach (cases[i]) begin
            resp_delays.push_back(int'($urandom % 7));
            credit_delays.push_back(int'($urandom % 7));
        end
        cycle_limit = cases.size() * 20 + 100;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #(SAMPLE_DLY);
        check_value("cpu_ready", {31'd0, cpu_ready}, 32'd1);
        check_value("cpu_data_valid", {31'd0, cpu_data_valid}, 32'd0);
        check_value("bus_req_valid", {31'd0, bus_req_valid}, 32'd0);
        foreach (cases[i]) begin
            case (cases[i].op)
                2'd0:    run_store(cases[i]);
                2'd1:    run_cached_load(cases[i]);
                2'd2:    run_uncached_load(cases[i]);
                default: begin
                    errors++;
                    $display("case %0d has an unknown operation", i);
                end
            endcase
        end
        @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- uncache_channel.sv
`timescale 1ns/10ps

module uncache_channel #(
    parameter int BUS_CREDITS = 2
) (
    input  logic                               clk,
    input  logic                               rst,

    input  logic                               unc_valid,
    input  logic [mem_bus_pkg::BUS_ADDR_W-1:0] unc_addr,
    output logic                               unc_ready,
    output logic                               unc_data_ok,
    output logic [mem_bus_pkg::BUS_DATA_W-1:0] unc_rdata,

    output logic                               bus_req_valid,
    output mem_bus_pkg::bus_req_t              bus_req,
    input  logic                               bus_credit,
    input  logic                               bus_resp_valid,
    input  mem_bus_pkg::bus_resp_t             bus_resp
);

    localparam int CNT_W = $clog2(BUS_CREDITS + 1);

    logic [CNT_W-1:0]              credits;
    logic [mem_bus_pkg::TAG_W-1:0] tag_q;
    logic [mem_bus_pkg::TAG_W-1:0] pending_tag;
    logic                          outstanding;
    logic                          send;
    logic                          resp_hit;

    // Needs a free credit and nothing in flight
    assign send = unc_valid && !outstanding && (credits != '0);

    assign bus_req_valid = send;
    assign unc_ready     = send;

    always_comb begin
        bus_req.op   = mem_bus_pkg::OP_READ;
        bus_req.addr = {unc_addr[mem_bus_pkg::BUS_ADDR_W-1:2], 2'b00};
        bus_req.tag  = tag_q;
    end

    // Stale tags are dropped
    assign resp_hit    = outstanding && bus_resp_valid && (bus_resp.tag == pending_tag);
    assign unc_data_ok = resp_hit;
    assign unc_rdata   = bus_resp.data;

    // Send and credit return may coincide
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CNT_W'(BUS_CREDITS);
        end else if (send && !bus_credit) begin
            credits <= credits - 1'b1;
        end else if (!send && bus_credit) begin
            credits <= credits + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tag_q       <= '0;
            outstanding <= 1'b0;
        end else if (send) begin
            tag_q       <= tag_q + 1'b1;
            outstanding <= 1'b1;
        end else if (resp_hit) begin
            outstanding <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            pending_tag <= tag_q;
        end
    end

endmodule
